//--- build.f
rtl/fp_fmt_pkg.sv
rtl/slice_op_pkg.sv
rtl/noncomp_lane.sv
rtl/slice_pipe.sv
rtl/result_packer.sv
rtl/multifmt_slice.sv
testbench/multifmt_slice_sva.sv
testbench/tb_multifmt_slice.sv

//--- run.sh
#!/bin/sh
# Build the slice testbench with Verilator and run it
# The run counts as passed only when the testbench prints its pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_multifmt_slice -f build.f \
  && ./obj_dir/Vtb_multifmt_slice | tee /dev/stderr | grep -q "Simulation passed" \
  && echo "run ok" \
  || { echo "run not ok" >&2; exit 1; }

//--- testbench/tb_multifmt_slice.sv
/*
 * Testbench for the multi-format SIMD slice
 * Directed and random sign injection and min/max items with back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module tb_multifmt_slice;
  import fp_fmt_pkg::*;
  import slice_op_pkg::*;

  localparam int unsigned Width       = 64;
  localparam int unsigned NumPipeRegs = 2;
  localparam int unsigned NumLanes    = Width / 16;
  // 200 random items near half throughput plus about 100 directed cycles, wide margin
  localparam int unsigned TimeoutCycles = 4000;

  logic                clk_i, rst_i;
  logic [Width-1:0]    op_a_i, op_b_i;
  slice_op_e           op_i;
  fp_fmt_e             fmt_i;
  logic                vectorial_i;
  logic [NumLanes-1:0] simd_mask_i;
  logic                in_valid_i, in_ready_o;
  logic [Width-1:0]    result_o;
  status_t             status_o;
  logic                out_valid_o, out_ready_i;

  logic [31:0]      lfsr;
  int unsigned      cycle_cnt = 0;
  int unsigned      step_cnt  = 0;
  bit               bp_mode, check_latency;
  logic [Width-1:0] exp_res_q [$]; // Expected items in flight, oldest first
  status_t          exp_st_q  [$];
  int unsigned      in_step_q [$];

  multifmt_slice #(
    .Width       ( Width       ),
    .NumPipeRegs ( NumPipeRegs )
  ) i_multifmt_slice (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    assert (cycle_cnt < TimeoutCycles) else report_fail("timed out waiting for the DUT");
  end

  // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic logic [Width-1:0] rand_operand();
    logic [Width-1:0] v;
    v = rand_bits(64);
    case (rand_bits(2))
      64'd0:   v = v | 64'h7F80_7C00_7F80_7C00; // Inf or NaN in every element
      64'd1:   v = v & 64'h8000_0000_8000_0000; // Signed zeros
      default: ;
    endcase
    return v;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic [31:0] elem_op(input logic [31:0] a, input logic [31:0] b,
                                          input slice_op_e op, input bit is32,
                                          output bit nv);
    int unsigned w;
    logic [31:0] mag_mask, ma, mb, inf, qbit;
    logic        sa, sb, na, nb, s, a_less;
    w        = is32 ? 32 : 16;
    mag_mask = is32 ? 32'h7FFF_FFFF : 32'h0000_7FFF;
    inf      = is32 ? 32'h7F80_0000 : 32'h0000_7C00;
    qbit     = is32 ? 32'h0040_0000 : 32'h0000_0200; // Quiet bit of the mantissa
    sa       = a[w-1];
    sb       = b[w-1];
    ma       = a & mag_mask;
    mb       = b & mag_mask;
    na       = ma > inf;
    nb       = mb > inf;
    nv       = 1'b0;
    if (op == FMIN || op == FMAX) begin
      nv = (na && ((a & qbit) == 0)) || (nb && ((b & qbit) == 0));
      if (na && nb) return is32 ? 32'h7FC0_0000 : 32'h0000_7E00;
      if (na) return b;
      if (nb) return a;
      if (sa != sb) a_less = sa; // Also puts -0 below +0
      else if (sa) a_less = ma > mb;
      else a_less = ma < mb;
      return ((op == FMIN) == a_less) ? a : b;
    end
    case (op)
      SGNJN:   s = ~sb;
      SGNJX:   s = sa ^ sb;
      default: s = sb;
    endcase
    return ({31'b0, s} << (w - 1)) | ma;
  endfunction

  task automatic predict(output logic [Width-1:0] res, output status_t st);
    bit               is32, nv;
    int unsigned      w, n;
    logic [Width-1:0] sh_a, sh_b;
    logic [31:0]      e;
    is32 = (fmt_i == FP32);
    w    = is32 ? 32 : 16;
    n    = vectorial_i ? Width / w : 1;
    res  = '1; // Unused fields stay NaN-boxed
    st   = '0;
    for (int unsigned i = 0; i < n; i++) begin
      sh_a = op_a_i >> (i * w);
      sh_b = op_b_i >> (i * w);
      e = elem_op(is32 ? sh_a[31:0] : {16'h0, sh_a[15:0]},
                  is32 ? sh_b[31:0] : {16'h0, sh_b[15:0]}, op_i, is32, nv);
      if (is32) res[i*32 +: 32] = e;
      else res[i*16 +: 16] = e[15:0];
      if (nv && simd_mask_i[i]) st[NV_BIT] = 1'b1;
    end
  endtask

  // ------------------------------
  // Handshake and scoreboard
  // ------------------------------
  task automatic clock_step(output bit in_fire);
    logic [Width-1:0] exp_res;
    status_t          exp_st;
    @(posedge clk_i);
    step_cnt++;
    in_fire = in_valid_i && in_ready_o;
    if (in_fire) begin
      predict(exp_res, exp_st);
      exp_res_q.push_back(exp_res);
      exp_st_q.push_back(exp_st);
      in_step_q.push_back(step_cnt);
    end
    if (out_valid_o && out_ready_i) begin
      assert (exp_res_q.size() > 0) else report_fail("output valid with no item in flight");
      assert (result_o === exp_res_q[0]) else report_fail($sformatf(
          "mismatch result_o: got %h expected %h", result_o, exp_res_q[0]));
      assert (status_o === exp_st_q[0]) else report_fail($sformatf(
          "mismatch status_o: got %h expected %h", status_o, exp_st_q[0]));
      if (check_latency) begin
        assert (step_cnt - in_step_q[0] == NumPipeRegs) else report_fail($sformatf(
            "mismatch latency: got %h expected %h", step_cnt - in_step_q[0], NumPipeRegs));
      end
      void'(exp_res_q.pop_front());
      void'(exp_st_q.pop_front());
      void'(in_step_q.pop_front());
    end
    @(negedge clk_i);
    if (bp_mode) out_ready_i = (rand_bits(1) != 0);
  endtask

  task automatic load(input logic [Width-1:0] a, input logic [Width-1:0] b,
                      input slice_op_e op, input fp_fmt_e fmt, input logic vec,
                      input logic [NumLanes-1:0] mask);
    op_a_i      = a;
    op_b_i      = b;
    op_i        = op;
    fmt_i       = fmt;
    vectorial_i = vec;
    simd_mask_i = mask;
    in_valid_i  = 1'b1;
  endtask

  task automatic load_random();
    logic [Width-1:0] a, b;
    logic [63:0]      r;
    a = rand_operand();
    b = rand_operand();
    r = rand_bits(9);
    load(a, b, slice_op_e'(r[8:6] % 3'd5), fp_fmt_e'(r[5]), r[4], r[3:0]);
  endtask

  task automatic wait_accept();
    bit fire;
    fire = 1'b0;
    while (!fire) begin
      clock_step(fire);
    end
    in_valid_i = 1'b0;
  endtask

  task automatic send(input logic [Width-1:0] a, input logic [Width-1:0] b,
                      input slice_op_e op, input fp_fmt_e fmt, input logic vec,
                      input logic [NumLanes-1:0] mask);
    load(a, b, op, fmt, vec, mask);
    wait_accept();
  endtask

  task automatic drain();
    bit fire;
    while (exp_res_q.size() > 0) begin
      clock_step(fire);
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_scalar_fp32_sgnj();
    send(64'h0123_4567_BF80_0000, 64'h89AB_CDEF_4000_0000, SGNJ, FP32, 1'b0, 4'hF);
    send(64'h0123_4567_BF80_0000, 64'h89AB_CDEF_4000_0000, SGNJN, FP32, 1'b0, 4'hF);
    send(64'h0123_4567_BF80_0000, 64'h0000_0000_C040_0000, SGNJX, FP32, 1'b0, 4'hF);
    drain();
  endtask

  task automatic test_scalar_fp16_sgnj();
    send(64'h1111_2222_3333_BC00, 64'h4444_5555_6666_4200, SGNJ, FP16, 1'b0, 4'hF);
    send(64'h1111_2222_3333_BC00, 64'h4444_5555_6666_4200, SGNJN, FP16, 1'b0, 4'hF);
    send(64'h1111_2222_3333_3C00, 64'h4444_5555_6666_C200, SGNJX, FP16, 1'b0, 4'hF);
    drain();
  endtask

  // Lane 0 signaling NaN, lane 1 one quiet NaN, lane 2 two NaNs, lane 3 numbers
  task automatic test_vector_fp16_minmax();
    send(64'hC000_7E00_7E00_7D00, 64'h3C00_FE01_4000_3C00, FMIN, FP16, 1'b1, 4'hF);
    send(64'hC000_7E00_7E00_7D00, 64'h3C00_FE01_4000_3C00, FMAX, FP16, 1'b1, 4'hF);
    send(64'hC000_7E00_7E00_7D00, 64'h3C00_FE01_4000_3C00, FMIN, FP16, 1'b1, 4'hE);
    send(64'hC000_7E00_7E00_7D00, 64'h3C00_FE01_4000_3C00, FMAX, FP16, 1'b1, 4'hE);
    drain();
  endtask

  task automatic test_vector_fp32_minmax();
    send(64'h8000_0000_7F80_0001, 64'h0000_0000_7FC0_0001, FMAX, FP32, 1'b1, 4'h3);
    send(64'h8000_0000_7F80_0001, 64'h0000_0000_7FC0_0001, FMIN, FP32, 1'b1, 4'h2);
    send(64'h0000_0000_C000_0000, 64'h8000_0000_7FC0_0000, FMIN, FP32, 1'b1, 4'h3);
    send(64'h0000_0000_C000_0000, 64'h8000_0000_7FC0_0000, FMAX, FP32, 1'b1, 4'h3);
    drain();
  endtask

  task automatic test_latency_backpressure();
    bit          fire;
    int unsigned accepted;
    check_latency = 1'b1;
    repeat (4) begin
      load_random();
      wait_accept();
    end
    drain();
    check_latency = 1'b0;
    out_ready_i   = 1'b0;
    accepted      = 0;
    load_random();
    repeat (5) begin
      clock_step(fire);
      if (fire) begin
        accepted++;
        load_random();
      end
    end
    assert (accepted == NumPipeRegs) else report_fail($sformatf(
        "mismatch accepted: got %h expected %h", accepted, NumPipeRegs));
    assert (!in_ready_o) else report_fail("in_ready_o stayed high with a full stalled pipe");
    out_ready_i = 1'b1;
    wait_accept();
    drain();
  endtask

  task automatic test_random();
    bp_mode = 1'b1;
    repeat (200) begin
      load_random();
      wait_accept();
    end
    bp_mode     = 1'b0;
    out_ready_i = 1'b1;
    drain();
  endtask

  initial begin
    lfsr          = 32'hded944c9;
    bp_mode       = 1'b0;
    check_latency = 1'b0;
    rst_i         = 1'b1;
    op_a_i        = '0;
    op_b_i        = '0;
    op_i          = SGNJ;
    fmt_i         = FP32;
    vectorial_i   = 1'b0;
    simd_mask_i   = '0;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    test_scalar_fp32_sgnj();
    test_scalar_fp16_sgnj();
    test_vector_fp16_minmax();
    test_vector_fp32_minmax();
    test_latency_backpressure();
    test_random();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/multifmt_slice_sva.sv
/*
 * Handshake assertions for the SIMD slice, bound to its top level
 */
`timescale 1ns/1ps
`default_nettype none

module multifmt_slice_sva #(
  parameter int unsigned Width = 64
) (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  in_ready_o,
  input logic [Width-1:0]      result_o,
  input slice_op_pkg::status_t status_o,
  input logic                  out_valid_o,
  input logic                  out_ready_i
);

  // Pipeline comes out of reset empty
  valid_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
    else $error("out_valid_o high right after reset");

  // A stalled output item must hold still
  stall_holds_output: assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(status_o))
    else $error("output item changed while stalled");

  ready_follows_out_ready: assert property (@(posedge clk_i) disable iff (rst_i)
      out_ready_i |-> in_ready_o)
    else $error("in_ready_o low while out_ready_i high");

endmodule

bind multifmt_slice multifmt_slice_sva #(.Width(Width)) i_multifmt_slice_sva (
  .clk_i, .rst_i, .in_ready_o, .result_o, .status_o, .out_valid_o, .out_ready_i
);

`default_nettype wire

//--- rtl/multifmt_slice.sv
/*
 * Multi-format SIMD slice for sign injection and min/max
 * Slices operands into lanes, pipelines the results, packs by format
 */
`timescale 1ns/1ps
`default_nettype none

module multifmt_slice #(
  parameter int unsigned Width       = 64,
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [Width-1:0]        op_a_i,
  input  logic [Width-1:0]        op_b_i,
  input  slice_op_pkg::slice_op_e op_i,
  input  fp_fmt_pkg::fp_fmt_e     fmt_i,
  input  logic                    vectorial_i,
  input  logic [Width/16-1:0]     simd_mask_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output logic [Width-1:0]        result_o,
  output slice_op_pkg::status_t   status_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i
);
  import fp_fmt_pkg::*;
  import slice_op_pkg::*;

  localparam int unsigned NumLanes = Width / FP16_WIDTH;
  localparam int unsigned Lanes32  = Width / FP32_WIDTH; // Lanes wide enough for FP32

  logic [Width-1:0]       slot32, slot16;  // Lane results placed per format
  logic [Width-1:0]       lane_result;
  status_t [NumLanes-1:0] lane_status;
  logic [NumLanes-1:0]    lane_active, status_mask;
  logic [Width-1:0]       pipe_result;
  status_t [NumLanes-1:0] pipe_status;
  logic [NumLanes-1:0]    pipe_mask;
  fp_fmt_e                pipe_fmt;
  logic                   pipe_vec;

  // ------------------------------
  // Lanes
  // ------------------------------
  for (genvar i = 0; i < NumLanes; i++) begin : gen_lanes
    localparam int unsigned LaneWidth = (i < Lanes32) ? FP32_WIDTH : FP16_WIDTH;

    logic [Width-1:0]     a_shift, b_shift;
    logic [LaneWidth-1:0] lane_res;

    assign a_shift = op_a_i >> (i * fp_width(fmt_i)); // Element i of the current format
    assign b_shift = op_b_i >> (i * fp_width(fmt_i));

    noncomp_lane #(
      .LaneWidth ( LaneWidth )
    ) i_noncomp_lane (
      .a_i      ( a_shift[LaneWidth-1:0] ),
      .b_i      ( b_shift[LaneWidth-1:0] ),
      .op_i     ( op_i                   ),
      .fmt_i    ( fmt_i                  ),
      .result_o ( lane_res               ),
      .status_o ( lane_status[i]         )
    );

    assign slot16[i*16 +: 16] = lane_res[15:0];
    if (i < Lanes32) begin : gen_slot32
      assign slot32[i*32 +: 32] = lane_res[31:0];
    end

    // Upper lanes only work on vectors that reach them
    assign lane_active[i] = (i == 0) ||
                            (vectorial_i && (i < ((fmt_i == FP32) ? Lanes32 : NumLanes)));
  end

  assign lane_result = (fmt_i == FP32) ? slot32 : slot16;
  assign status_mask = lane_active & simd_mask_i;

  slice_pipe #(
    .NumPipeRegs ( NumPipeRegs ),
    .NumLanes    ( NumLanes    )
  ) i_slice_pipe (
    .clk_i,
    .rst_i,
    .in_valid_i,
    .in_ready_o,
    .lane_result_i ( lane_result ),
    .lane_status_i ( lane_status ),
    .status_mask_i ( status_mask ),
    .fmt_i,
    .vectorial_i,
    .out_valid_o,
    .out_ready_i,
    .lane_result_o ( pipe_result ),
    .lane_status_o ( pipe_status ),
    .status_mask_o ( pipe_mask   ),
    .fmt_o         ( pipe_fmt    ),
    .vectorial_o   ( pipe_vec    )
  );

  result_packer #(
    .Width ( Width )
  ) i_result_packer (
    .lane_result_i ( pipe_result ),
    .lane_status_i ( pipe_status ),
    .status_mask_i ( pipe_mask   ),
    .fmt_i         ( pipe_fmt    ),
    .vectorial_i   ( pipe_vec    ),
    .result_o,
    .status_o
  );

endmodule

`default_nettype wire

//--- rtl/result_packer.sv
/*
 * Result packing at the slice output
 * NaN-boxes scalar and unused fields with ones, ORs masked lane flags
 */
`timescale 1ns/1ps
`default_nettype none

module result_packer #(
  parameter  int unsigned Width    = 64,
  localparam int unsigned NumLanes = Width / fp_fmt_pkg::FP16_WIDTH
) (
  input  logic [Width-1:0]                     lane_result_i,
  input  slice_op_pkg::status_t [NumLanes-1:0] lane_status_i,
  input  logic [NumLanes-1:0]                  status_mask_i,
  input  fp_fmt_pkg::fp_fmt_e                  fmt_i,
  input  logic                                 vectorial_i,
  output logic [Width-1:0]                     result_o,
  output slice_op_pkg::status_t                status_o
);
  import fp_fmt_pkg::*;
  import slice_op_pkg::*;

  localparam int unsigned NumFormats = 2;

  logic [NumFormats-1:0][Width-1:0] fmt_result; // Packed candidate per format

  // ------------------------------
  // Per-format packing
  // ------------------------------
  for (genvar f = 0; f < NumFormats; f++) begin : gen_formats
    localparam int unsigned FmtWidth = fp_width(fp_fmt_e'(f));
    localparam int unsigned FmtLanes = Width / FmtWidth;

    // Lane 0 always carries data, upper fields only for vector results
    for (genvar j = 0; j < FmtLanes; j++) begin : gen_fields
      assign fmt_result[f][j*FmtWidth +: FmtWidth] =
          ((j == 0) || vectorial_i) ? lane_result_i[j*FmtWidth +: FmtWidth] : '1;
    end
  end

  assign result_o = fmt_result[fmt_i];

  // ------------------------------
  // Status collapse
  // ------------------------------
  always_comb begin : status_collapse
    status_o = '0;
    for (int i = 0; i < int'(NumLanes); i++) begin
      if (status_mask_i[i]) begin
        status_o = status_o | lane_status_i[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/slice_pipe.sv
/*
 * Shared valid/ready pipeline for all lanes of the slice
 * One valid chain keeps the lanes in lockstep under back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module slice_pipe #(
  parameter  int unsigned NumPipeRegs = 2,
  parameter  int unsigned NumLanes    = 4,
  localparam int unsigned Width       = NumLanes * fp_fmt_pkg::FP16_WIDTH
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  in_valid_i,
  output logic                                  in_ready_o,
  input  logic [Width-1:0]                      lane_result_i,
  input  slice_op_pkg::status_t [NumLanes-1:0]  lane_status_i,
  input  logic [NumLanes-1:0]                   status_mask_i,
  input  fp_fmt_pkg::fp_fmt_e                   fmt_i,
  input  logic                                  vectorial_i,
  output logic                                  out_valid_o,
  input  logic                                  out_ready_i,
  output logic [Width-1:0]                      lane_result_o,
  output slice_op_pkg::status_t [NumLanes-1:0]  lane_status_o,
  output logic [NumLanes-1:0]                   status_mask_o,
  output fp_fmt_pkg::fp_fmt_e                   fmt_o,
  output logic                                  vectorial_o
);
  import fp_fmt_pkg::*;
  import slice_op_pkg::*;

  // Index i holds the item after i register stages
  logic                   valid_q  [0:NumPipeRegs];
  logic                   ready    [0:NumPipeRegs];
  logic [Width-1:0]       result_q [0:NumPipeRegs];
  status_t [NumLanes-1:0] status_q [0:NumPipeRegs];
  logic [NumLanes-1:0]    mask_q   [0:NumPipeRegs];
  fp_fmt_e                fmt_q    [0:NumPipeRegs];
  logic                   vec_q    [0:NumPipeRegs];

  assign valid_q[0]  = in_valid_i;
  assign result_q[0] = lane_result_i;
  assign status_q[0] = lane_status_i;
  assign mask_q[0]   = status_mask_i;
  assign fmt_q[0]    = fmt_i;
  assign vec_q[0]    = vectorial_i;

  // ------------------------------
  // Register stages
  // ------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stages
    logic stage_ena;

    // Advance when downstream takes the item or only holds a bubble
    assign ready[i]  = ready[i+1] | ~valid_q[i+1];
    assign stage_ena = ready[i] & valid_q[i]; // Payload moves only with a real item

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ena) begin
        result_q[i+1] <= result_q[i];
        status_q[i+1] <= status_q[i];
        mask_q[i+1]   <= mask_q[i];
        fmt_q[i+1]    <= fmt_q[i];
        vec_q[i+1]    <= vec_q[i];
      end
    end
  end

  assign ready[NumPipeRegs] = out_ready_i; // Driven by downstream
  assign in_ready_o         = ready[0];
  assign out_valid_o        = valid_q[NumPipeRegs];
  assign lane_result_o      = result_q[NumPipeRegs];
  assign lane_status_o      = status_q[NumPipeRegs];
  assign status_mask_o      = mask_q[NumPipeRegs];
  assign fmt_o              = fmt_q[NumPipeRegs];
  assign vectorial_o        = vec_q[NumPipeRegs];

endmodule

`default_nettype wire

//--- rtl/noncomp_lane.sv
/*
 * One lane of the slice: sign injection and IEEE minNum/maxNum
 * Purely combinational, FP16 results in a 32-bit lane are NaN-boxed
 */
`timescale 1ns/1ps
`default_nettype none

module noncomp_lane #(
  parameter int unsigned LaneWidth = 32
) (
  input  logic [LaneWidth-1:0]    a_i,
  input  logic [LaneWidth-1:0]    b_i,
  input  slice_op_pkg::slice_op_e op_i,
  input  fp_fmt_pkg::fp_fmt_e     fmt_i,
  output logic [LaneWidth-1:0]    result_o,
  output slice_op_pkg::status_t   status_o
);
  import fp_fmt_pkg::*;
  import slice_op_pkg::*;

  logic        is_fp32;
  logic [31:0] a_ext, b_ext;
  logic        sign_a, sign_b;
  logic [30:0] mag_a, mag_b;
  logic [30:0] inf_mag;
  logic        nan_a, nan_b;
  logic        snan_a, snan_b;
  logic        a_lt_b;
  logic [31:0] qnan;
  logic [31:0] res_ext;

  // Rebuild an element from sign and magnitude, boxing FP16 with ones
  function automatic logic [31:0] box(input logic fp32, input logic sign,
                                      input logic [30:0] mag);
    return fp32 ? {sign, mag} : {16'hFFFF, sign, mag[14:0]};
  endfunction

  // ------------------------------
  // Field extraction
  // ------------------------------
  assign is_fp32 = (LaneWidth == FP32_WIDTH) && (fmt_i == FP32); // 16-bit lanes are FP16 only
  assign a_ext   = 32'(a_i);
  assign b_ext   = 32'(b_i);

  assign sign_a  = is_fp32 ? a_ext[31] : a_ext[15];
  assign sign_b  = is_fp32 ? b_ext[31] : b_ext[15];
  assign mag_a   = is_fp32 ? a_ext[30:0] : {16'b0, a_ext[14:0]};
  assign mag_b   = is_fp32 ? b_ext[30:0] : {16'b0, b_ext[14:0]};
  assign inf_mag = is_fp32 ? 31'h7F80_0000 : 31'h0000_7C00;
  assign qnan    = is_fp32 ? FP32_QNAN : {16'hFFFF, FP16_QNAN};

  // Any magnitude above infinity is a NaN, a clear MSB of the mantissa makes it signaling
  assign nan_a  = mag_a > inf_mag;
  assign nan_b  = mag_b > inf_mag;
  assign snan_a = nan_a & ~(is_fp32 ? a_ext[22] : a_ext[9]);
  assign snan_b = nan_b & ~(is_fp32 ? b_ext[22] : b_ext[9]);

  // Sign-magnitude ordering, -0 sorts below +0
  always_comb begin : compare
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b; // Both negative
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  // ------------------------------
  // Operation select
  // ------------------------------
  always_comb begin : op_select
    res_ext  = box(is_fp32, sign_a, mag_a);
    status_o = '0;
    case (op_i)
      SGNJ:  res_ext = box(is_fp32, sign_b, mag_a);
      SGNJN: res_ext = box(is_fp32, ~sign_b, mag_a);
      SGNJX: res_ext = box(is_fp32, sign_a ^ sign_b, mag_a);
      FMIN, FMAX: begin
        status_o[NV_BIT] = snan_a | snan_b;
        if (nan_a && nan_b) begin
          res_ext = qnan;
        end else if (nan_a) begin
          res_ext = box(is_fp32, sign_b, mag_b); // Only a is NaN
        end else if (nan_b) begin
          res_ext = box(is_fp32, sign_a, mag_a);
        end else if ((op_i == FMIN) ? a_lt_b : ~a_lt_b) begin
          res_ext = box(is_fp32, sign_a, mag_a);
        end else begin
          res_ext = box(is_fp32, sign_b, mag_b);
        end
      end
      default: ;
    endcase
  end

  assign result_o = res_ext[LaneWidth-1:0];

endmodule

`default_nettype wire

//--- rtl/slice_op_pkg.sv
/*
 * Opcodes and status flags of the non-computational slice
 */
`default_nettype none

package slice_op_pkg;

  // Sign injection and min/max operations
  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    FMIN  = 3'd3,
    FMAX  = 3'd4
  } slice_op_e;

  // Flags ordered NV, DZ, OF, UF, NX from MSB down
  typedef logic [4:0] status_t;

  localparam int unsigned NV_BIT = 4; // Invalid operation

endpackage

`default_nettype wire

//--- rtl/fp_fmt_pkg.sv
/*
 * Floating-point format definitions for the SIMD slice
 * Encodes FP32 and FP16, their widths and canonical quiet NaNs
 */
`default_nettype none

package fp_fmt_pkg;

  // ------------------------------
  // Formats
  // ------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;

  // ------------------------------
  // Canonical NaNs
  // ------------------------------
  localparam logic [31:0] FP32_QNAN = 32'h7FC0_0000; // Positive quiet NaN, zero payload
  localparam logic [15:0] FP16_QNAN = 16'h7E00;

  // Bit width of one element of a format
  function automatic int unsigned fp_width(fp_fmt_e fmt);
    case (fmt)
      FP32:    return FP32_WIDTH;
      default: return FP16_WIDTH;
    endcase
  endfunction

endpackage

`default_nettype wire
